// ==== issue_consts.svh ====
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// Shared sizing for the issue stage

// Number of reservation station entries
`define RS_DEPTH 8

// Result tag width, gives 16 tags in flight
`define TAG_W 4

// Integer register width for RV32
`define XLEN 32

// Multiplier pipeline depth
// Partial products need at least two stages
`define MUL_STAGES 3

`endif

// ==== issue_pkg.sv ====
`include "issue_consts.svh"

package issue_pkg;

    // Operations accepted by the issue stage
    // Encoding fits in four bits with room left over
    typedef enum logic [3:0] {
        op_add   = 4'd0,
        op_sub   = 4'd1,
        op_and   = 4'd2,
        op_or    = 4'd3,
        op_xor   = 4'd4,
        op_sll   = 4'd5,
        op_srl   = 4'd6,
        op_sra   = 4'd7,
        op_slt   = 4'd8,
        op_sltu  = 4'd9,
        op_mul   = 4'd10,
        op_mulhu = 4'd11
    } alu_op_e;

    // Functional unit that executes an operation
    typedef enum logic {
        fu_alu = 1'b0,
        fu_mul = 1'b1
    } fu_sel_e;

    // Route multiplies to the multiplier, everything else to the ALU
    function automatic fu_sel_e unit_of(input alu_op_e op);
        if (op == op_mul || op == op_mulhu) begin
            return fu_mul;
        end
        return fu_alu;
    endfunction

    // One reservation station slot
    // A source is either a captured value or a tag still pending
    typedef struct packed {
        logic                valid;
        alu_op_e             op;
        logic                src1_ready;
        logic [`TAG_W-1:0]   src1_tag;
        logic [`XLEN-1:0]    src1_val;
        logic                src2_ready;
        logic [`TAG_W-1:0]   src2_tag;
        logic [`XLEN-1:0]    src2_val;
        logic [`TAG_W-1:0]   dest_tag;
    } rs_entry_t;

endpackage

// ==== issue_ifs.sv ====
`timescale 1ns/1ps
`include "issue_consts.svh"

// Request from the station to one functional unit
// Taken on a rising edge when valid and ready are both high
interface fu_req_if;
    logic                 valid;
    issue_pkg::alu_op_e   op;
    logic [`XLEN-1:0]     a;
    logic [`XLEN-1:0]     b;
    logic [`TAG_W-1:0]    tag;
    // Level signal from the unit
    logic                 ready;

    modport issuer (
        output valid, op, a, b, tag,
        input  ready
    );

    modport unit (
        input  valid, op, a, b, tag,
        output ready
    );
endinterface

// Result from one functional unit toward the CDB arbiter
// Leaves the unit at the edge where valid and grant are both high
interface fu_result_if;
    logic                 valid;
    logic [`TAG_W-1:0]    tag;
    logic [`XLEN-1:0]     data;
    // Driven back by the arbiter
    logic                 grant;

    modport unit (
        output valid, tag, data,
        input  grant
    );

    modport arbiter (
        input  valid, tag, data,
        output grant
    );
endinterface

// Common data bus broadcast
// Valid is a single-cycle strobe per result
interface cdb_if;
    logic                 valid;
    logic [`TAG_W-1:0]    tag;
    logic [`XLEN-1:0]     data;

    modport driver (
        output valid, tag, data
    );

    modport listener (
        input  valid, tag, data
    );
endinterface

// ==== reservation_station.sv ====
`timescale 1ns/1ps
`include "issue_consts.svh"

module reservation_station (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dispatch_valid,
    input  issue_pkg::alu_op_e    dispatch_op,
    input  logic                  dispatch_src1_ready,
    input  logic [`TAG_W-1:0]     dispatch_src1_tag,
    input  logic [`XLEN-1:0]      dispatch_src1_val,
    input  logic                  dispatch_src2_ready,
    input  logic [`TAG_W-1:0]     dispatch_src2_tag,
    input  logic [`XLEN-1:0]      dispatch_src2_val,
    input  logic [`TAG_W-1:0]     dispatch_dest_tag,
    output logic                  full,
    fu_req_if.issuer              alu_req,
    fu_req_if.issuer              mul_req,
    cdb_if.listener               cdb
);

    localparam int IDX_W = $clog2(`RS_DEPTH);

    // Entry table
    issue_pkg::rs_entry_t entries [`RS_DEPTH];

    // Incoming entry after the same-cycle CDB bypass
    issue_pkg::rs_entry_t new_entry;

    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] alu_idx;
    logic [IDX_W-1:0] mul_idx;
    logic             alu_found;
    logic             mul_found;
    logic             dispatch_take;
    logic             alu_take;
    logic             mul_take;

    // Lowest free slot, and full when no slot is free
    always_comb begin
        free_idx = '0;
        full     = 1'b1;
        // Walk downward so the lowest index wins
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                free_idx = IDX_W'(i);
                full     = 1'b0;
            end
        end
    end

    // Pick the oldest-position ready entry per unit
    always_comb begin
        alu_found = 1'b0;
        alu_idx   = '0;
        mul_found = 1'b0;
        mul_idx   = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (entries[i].valid && entries[i].src1_ready && entries[i].src2_ready) begin
                if (issue_pkg::unit_of(entries[i].op) == issue_pkg::fu_mul) begin
                    mul_found = 1'b1;
                    mul_idx   = IDX_W'(i);
                end else begin
                    alu_found = 1'b1;
                    alu_idx   = IDX_W'(i);
                end
            end
        end
    end

    // Build the dispatched entry
    always_comb begin
        new_entry.valid    = 1'b1;
        new_entry.op       = dispatch_op;
        new_entry.dest_tag = dispatch_dest_tag;
        new_entry.src1_tag = dispatch_src1_tag;
        new_entry.src2_tag = dispatch_src2_tag;

        // Source 1, catch a result passing by on the CDB this cycle
        if (dispatch_src1_ready) begin
            new_entry.src1_ready = 1'b1;
            new_entry.src1_val   = dispatch_src1_val;
        end else if (cdb.valid && cdb.tag == dispatch_src1_tag) begin
            new_entry.src1_ready = 1'b1;
            new_entry.src1_val   = cdb.data;
        end else begin
            new_entry.src1_ready = 1'b0;
            new_entry.src1_val   = dispatch_src1_val;
        end

        // Source 2, same bypass
        if (dispatch_src2_ready) begin
            new_entry.src2_ready = 1'b1;
            new_entry.src2_val   = dispatch_src2_val;
        end else if (cdb.valid && cdb.tag == dispatch_src2_tag) begin
            new_entry.src2_ready = 1'b1;
            new_entry.src2_val   = cdb.data;
        end else begin
            new_entry.src2_ready = 1'b0;
            new_entry.src2_val   = dispatch_src2_val;
        end
    end

    assign dispatch_take = dispatch_valid && !full;
    assign alu_take      = alu_req.valid && alu_req.ready;
    assign mul_take      = mul_req.valid && mul_req.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            // Wakeup of waiting sources from the broadcast
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (entries[i].valid && cdb.valid) begin
                    if (!entries[i].src1_ready && cdb.tag == entries[i].src1_tag) begin
                        entries[i].src1_ready <= 1'b1;
                        entries[i].src1_val   <= cdb.data;
                    end
                    if (!entries[i].src2_ready && cdb.tag == entries[i].src2_tag) begin
                        entries[i].src2_ready <= 1'b1;
                        entries[i].src2_val   <= cdb.data;
                    end
                end
            end
            // Free issued entries, one per unit at most
            if (alu_take) begin
                entries[alu_idx].valid <= 1'b0;
            end
            if (mul_take) begin
                entries[mul_idx].valid <= 1'b0;
            end
            // Free slot is never the one being issued
            if (dispatch_take) begin
                entries[free_idx] <= new_entry;
            end
        end
    end

    // ALU request port
    assign alu_req.valid = alu_found;
    assign alu_req.op    = entries[alu_idx].op;
    assign alu_req.a     = entries[alu_idx].src1_val;
    assign alu_req.b     = entries[alu_idx].src2_val;
    assign alu_req.tag   = entries[alu_idx].dest_tag;

    // Multiplier request port
    assign mul_req.valid = mul_found;
    assign mul_req.op    = entries[mul_idx].op;
    assign mul_req.a     = entries[mul_idx].src1_val;
    assign mul_req.b     = entries[mul_idx].src2_val;
    assign mul_req.tag   = entries[mul_idx].dest_tag;

endmodule

// ==== alu_unit.sv ====
`timescale 1ns/1ps
`include "issue_consts.svh"

module alu_unit (
    input  logic     clk,
    input  logic     rst,
    fu_req_if.unit   req,
    fu_result_if.unit res
);

    logic [4:0]           shamt;
    logic [`XLEN-1:0]     result;
    logic                 out_valid;
    logic [`TAG_W-1:0]    out_tag;
    logic [`XLEN-1:0]     out_data;
    logic                 take;

    // Shift amount from the low five bits of b
    assign shamt = req.b[4:0];

    always_comb begin
        case (req.op)
            issue_pkg::op_add:  result = req.a + req.b;
            issue_pkg::op_sub:  result = req.a - req.b;
            issue_pkg::op_and:  result = req.a & req.b;
            issue_pkg::op_or:   result = req.a | req.b;
            issue_pkg::op_xor:  result = req.a ^ req.b;
            issue_pkg::op_sll:  result = req.a << shamt;
            issue_pkg::op_srl:  result = req.a >> shamt;
            issue_pkg::op_sra:  result = $signed(req.a) >>> shamt;
            issue_pkg::op_slt:  result = {{(`XLEN-1){1'b0}}, $signed(req.a) < $signed(req.b)};
            issue_pkg::op_sltu: result = {{(`XLEN-1){1'b0}}, req.a < req.b};
            // Multiplies never arrive here
            default:            result = '0;
        endcase
    end

    // Accept when the holding register is empty or leaving this cycle
    assign req.ready = !out_valid || res.grant;
    assign take      = req.valid && req.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (res.grant) begin
            out_valid <= 1'b0;
        end
    end

    // Result payload, held while the CDB is busy
    always_ff @(posedge clk) begin
        if (take) begin
            out_tag  <= req.tag;
            out_data <= result;
        end
    end

    assign res.valid = out_valid;
    assign res.tag   = out_tag;
    assign res.data  = out_data;

endmodule

// ==== mult_unit.sv ====
`timescale 1ns/1ps
`include "issue_consts.svh"

module mult_unit (
    input  logic      clk,
    input  logic      rst,
    fu_req_if.unit    req,
    fu_result_if.unit res
);

    localparam int HALF = `XLEN / 2;
    localparam int LAST = `MUL_STAGES - 1;

    // Per-stage control
    logic [`MUL_STAGES-1:0] st_valid;
    logic                   st_hi  [`MUL_STAGES];
    logic [`TAG_W-1:0]      st_tag [`MUL_STAGES];

    // First stage holds four half-width partial products
    logic [`XLEN-1:0]       pp_ll;
    logic [`XLEN-1:0]       pp_lh;
    logic [`XLEN-1:0]       pp_hl;
    logic [`XLEN-1:0]       pp_hh;

    // Full product from stage 1 onward
    logic [2*`XLEN-1:0]     st_prod [1:LAST];

    // Pipeline never stalls, so the unit always accepts
    assign req.ready = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            st_valid <= '0;
        end else begin
            st_valid[0] <= req.valid && req.ready;
            for (int i = 1; i < `MUL_STAGES; i++) begin
                st_valid[i] <= st_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        st_tag[0] <= req.tag;
        st_hi[0]  <= (req.op == issue_pkg::op_mulhu);
        pp_ll     <= req.a[HALF-1:0] * req.b[HALF-1:0];
        pp_lh     <= req.a[HALF-1:0] * req.b[`XLEN-1:HALF];
        pp_hl     <= req.a[`XLEN-1:HALF] * req.b[HALF-1:0];
        pp_hh     <= req.a[`XLEN-1:HALF] * req.b[`XLEN-1:HALF];
        for (int i = 1; i < `MUL_STAGES; i++) begin
            st_tag[i] <= st_tag[i-1];
            st_hi[i]  <= st_hi[i-1];
        end
        // Cross terms sit half a word up
        st_prod[1] <= {pp_hh, pp_ll}
                    + {{HALF{1'b0}}, pp_lh, {HALF{1'b0}}}
                    + {{HALF{1'b0}}, pp_hl, {HALF{1'b0}}};
        for (int i = 2; i < `MUL_STAGES; i++) begin
            st_prod[i] <= st_prod[i-1];
        end
    end

    // Last stage picks the word, single-cycle valid
    assign res.valid = st_valid[LAST];
    assign res.tag   = st_tag[LAST];
    assign res.data  = st_hi[LAST] ? st_prod[LAST][2*`XLEN-1:`XLEN]
                                   : st_prod[LAST][`XLEN-1:0];

endmodule

// ==== cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter (
    fu_result_if.arbiter mul_res,
    fu_result_if.arbiter alu_res,
    cdb_if.driver        cdb
);

    logic mul_win;
    logic alu_win;

    // Multiplier pipeline cannot stall, so it always wins
    assign mul_win = mul_res.valid;

    // ALU only when the multiplier is silent
    assign alu_win = alu_res.valid && !mul_res.valid;

    assign mul_res.grant = mul_win;
    assign alu_res.grant = alu_win;

    // Drive the broadcast from whichever unit holds the grant
    always_comb begin
        if (mul_win) begin
            cdb.valid = 1'b1;
            cdb.tag   = mul_res.tag;
            cdb.data  = mul_res.data;
        end else if (alu_win) begin
            cdb.valid = 1'b1;
            cdb.tag   = alu_res.tag;
            cdb.data  = alu_res.data;
        end else begin
            // Idle bus
            cdb.valid = 1'b0;
            cdb.tag   = '0;
            cdb.data  = '0;
        end
    end

endmodule

// ==== issue_core.sv ====
`timescale 1ns/1ps
`include "issue_consts.svh"

module issue_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dispatch_valid,
    input  issue_pkg::alu_op_e    dispatch_op,
    input  logic                  dispatch_src1_ready,
    input  logic [`TAG_W-1:0]     dispatch_src1_tag,
    input  logic [`XLEN-1:0]      dispatch_src1_val,
    input  logic                  dispatch_src2_ready,
    input  logic [`TAG_W-1:0]     dispatch_src2_tag,
    input  logic [`XLEN-1:0]      dispatch_src2_val,
    input  logic [`TAG_W-1:0]     dispatch_dest_tag,
    output logic                  full,
    output logic                  cdb_valid,
    output logic [`TAG_W-1:0]     cdb_tag,
    output logic [`XLEN-1:0]      cdb_data
);

    // Issue paths, one per unit
    fu_req_if    alu_req ();
    fu_req_if    mul_req ();

    // Result paths toward the arbiter
    fu_result_if alu_res ();
    fu_result_if mul_res ();

    // Broadcast that closes the wakeup loop
    cdb_if       cdb ();

    reservation_station u_rs (
        .clk                 (clk),
        .rst                 (rst),
        .dispatch_valid      (dispatch_valid),
        .dispatch_op         (dispatch_op),
        .dispatch_src1_ready (dispatch_src1_ready),
        .dispatch_src1_tag   (dispatch_src1_tag),
        .dispatch_src1_val   (dispatch_src1_val),
        .dispatch_src2_ready (dispatch_src2_ready),
        .dispatch_src2_tag   (dispatch_src2_tag),
        .dispatch_src2_val   (dispatch_src2_val),
        .dispatch_dest_tag   (dispatch_dest_tag),
        .full                (full),
        .alu_req             (alu_req),
        .mul_req             (mul_req),
        .cdb                 (cdb)
    );

    alu_unit u_alu (
        .clk (clk),
        .rst (rst),
        .req (alu_req),
        .res (alu_res)
    );

    mult_unit u_mul (
        .clk (clk),
        .rst (rst),
        .req (mul_req),
        .res (mul_res)
    );

    cdb_arbiter u_arb (
        .mul_res (mul_res),
        .alu_res (alu_res),
        .cdb     (cdb)
    );

    // Broadcast out to the ports
    assign cdb_valid = cdb.valid;
    assign cdb_tag   = cdb.tag;
    assign cdb_data  = cdb.data;

endmodule

// ==== tb_issue_core.sv ====
`timescale 1ns/1ps
`include "issue_consts.svh"

module tb_issue_core;

    localparam int MAX_ROWS = 48;
    localparam int NTAGS    = 1 << `TAG_W;

    logic                 clk;
    logic                 rst;
    logic                 dispatch_valid;
    issue_pkg::alu_op_e   dispatch_op;
    logic                 dispatch_src1_ready;
    logic [`TAG_W-1:0]    dispatch_src1_tag;
    logic [`XLEN-1:0]     dispatch_src1_val;
    logic                 dispatch_src2_ready;
    logic [`TAG_W-1:0]    dispatch_src2_tag;
    logic [`XLEN-1:0]     dispatch_src2_val;
    logic [`TAG_W-1:0]    dispatch_dest_tag;
    logic                 full;
    logic                 cdb_valid;
    logic [`TAG_W-1:0]    cdb_tag;
    logic [`XLEN-1:0]     cdb_data;

    // Stimulus table, a source ref of -1 means a literal operand
    issue_pkg::alu_op_e   row_op   [MAX_ROWS];
    int                   row_ref1 [MAX_ROWS];
    int                   row_ref2 [MAX_ROWS];
    logic [`XLEN-1:0]     row_val1 [MAX_ROWS];
    logic [`XLEN-1:0]     row_val2 [MAX_ROWS];
    logic [`XLEN-1:0]     row_exp  [MAX_ROWS];
    logic [`TAG_W-1:0]    row_tag  [MAX_ROWS];
    // Idle cycles after the row, -1 picks a random gap
    int                   row_gap  [MAX_ROWS];
    int                   n_rows;
    int                   test_first [6];
    string                test_name  [5];

    // Scoreboard keyed by tag
    logic [`XLEN-1:0]     exp_data [NTAGS];
    bit                   pending  [NTAGS];
    bit                   seen     [NTAGS];
    int                   pending_cnt;
    int                   errors;
    int                   checks;
    int                   tests_failed;
    bit                   full_seen;

    issue_core dut (
        .clk                 (clk),
        .rst                 (rst),
        .dispatch_valid      (dispatch_valid),
        .dispatch_op         (dispatch_op),
        .dispatch_src1_ready (dispatch_src1_ready),
        .dispatch_src1_tag   (dispatch_src1_tag),
        .dispatch_src1_val   (dispatch_src1_val),
        .dispatch_src2_ready (dispatch_src2_ready),
        .dispatch_src2_tag   (dispatch_src2_tag),
        .dispatch_src2_val   (dispatch_src2_val),
        .dispatch_dest_tag   (dispatch_dest_tag),
        .full                (full),
        .cdb_valid           (cdb_valid),
        .cdb_tag             (cdb_tag),
        .cdb_data            (cdb_data)
    );

    always #5 clk = ~clk;

    // Reference model of the RV32I and M operations
    function automatic logic [`XLEN-1:0] ref_result(input issue_pkg::alu_op_e op,
                                                   input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b);
        logic [2*`XLEN-1:0] prod;
        prod = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
        case (op)
            issue_pkg::op_add:   return a + b;
            issue_pkg::op_sub:   return a - b;
            issue_pkg::op_and:   return a & b;
            issue_pkg::op_or:    return a | b;
            issue_pkg::op_xor:   return a ^ b;
            issue_pkg::op_sll:   return a << b[4:0];
            issue_pkg::op_srl:   return a >> b[4:0];
            issue_pkg::op_sra:   return $signed(a) >>> b[4:0];
            issue_pkg::op_slt:   return ($signed(a) < $signed(b)) ? 1 : 0;
            issue_pkg::op_sltu:  return (a < b) ? 1 : 0;
            issue_pkg::op_mul:   return prod[`XLEN-1:0];
            issue_pkg::op_mulhu: return prod[2*`XLEN-1:`XLEN];
            default:             return '0;
        endcase
    endfunction

    // Expected value follows from the expected value of any referenced row
    task automatic add_row(input issue_pkg::alu_op_e op, input int ref1,
                           input logic [`XLEN-1:0] val1, input int ref2,
                           input logic [`XLEN-1:0] val2, input int tag, input int gap);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        a = (ref1 >= 0) ? row_exp[ref1] : val1;
        b = (ref2 >= 0) ? row_exp[ref2] : val2;
        row_op[n_rows]   = op;
        row_ref1[n_rows] = ref1;
        row_ref2[n_rows] = ref2;
        row_val1[n_rows] = val1;
        row_val2[n_rows] = val2;
        row_tag[n_rows]  = tag;
        row_gap[n_rows]  = gap;
        row_exp[n_rows]  = ref_result(op, a, b);
        n_rows++;
    endtask

    task automatic build_table();
        int base;
        // Ten ALU operations, no dependencies
        test_first[0] = n_rows;
        test_name[0]  = "alu operations";
        add_row(issue_pkg::op_add, -1, $urandom, -1, $urandom, 0, -1);
        add_row(issue_pkg::op_sub, -1, $urandom, -1, $urandom, 1, -1);
        add_row(issue_pkg::op_and, -1, $urandom, -1, $urandom, 2, -1);
        add_row(issue_pkg::op_or,  -1, $urandom, -1, $urandom, 3, -1);
        add_row(issue_pkg::op_xor, -1, $urandom, -1, $urandom, 4, -1);
        add_row(issue_pkg::op_sll, -1, $urandom, -1, $urandom, 5, -1);
        add_row(issue_pkg::op_srl, -1, $urandom | 32'h8000_0000, -1, $urandom, 6, -1);
        add_row(issue_pkg::op_sra, -1, $urandom | 32'h8000_0000, -1, $urandom, 7, -1);
        add_row(issue_pkg::op_slt,  -1, 32'hffff_fff0, -1, 32'd5, 8, -1);
        add_row(issue_pkg::op_sltu, -1, 32'hffff_fff0, -1, 32'd5, 9, -1);
        // Back to back multiplies
        test_first[1] = n_rows;
        test_name[1]  = "multiplies back to back";
        add_row(issue_pkg::op_mul,   -1, $urandom, -1, $urandom, 0, 0);
        add_row(issue_pkg::op_mulhu, -1, $urandom, -1, $urandom, 1, 0);
        add_row(issue_pkg::op_mulhu, -1, 32'hffff_ffff, -1, 32'hffff_ffff, 2, 0);
        add_row(issue_pkg::op_mul,   -1, $urandom, -1, $urandom, 3, 0);
        // One idle cycle after the producer puts its broadcast in the consumer's dispatch cycle
        test_first[2] = n_rows;
        test_name[2]  = "dependency chains";
        base = n_rows;
        add_row(issue_pkg::op_add, -1, $urandom, -1, $urandom, 0, 1);
        add_row(issue_pkg::op_sub, base, 0, -1, $urandom, 1, -1);
        add_row(issue_pkg::op_mul, base + 1, 0, base, 0, 2, -1);
        add_row(issue_pkg::op_xor, base + 2, 0, base, 0, 3, 0);
        // ALU and multiplier results fighting for the CDB
        test_first[3] = n_rows;
        test_name[3]  = "mixed collisions";
        base = n_rows;
        add_row(issue_pkg::op_mul,   -1, $urandom, -1, $urandom, 0, 0);
        add_row(issue_pkg::op_add,   -1, $urandom, -1, $urandom, 1, 0);
        add_row(issue_pkg::op_mulhu, -1, $urandom, -1, $urandom, 2, 0);
        add_row(issue_pkg::op_sub,   base, 0, -1, $urandom, 3, 0);
        add_row(issue_pkg::op_and,   -1, $urandom, -1, $urandom, 4, 0);
        add_row(issue_pkg::op_mul,   base + 1, 0, -1, $urandom, 5, 0);
        add_row(issue_pkg::op_or,    -1, $urandom, -1, $urandom, 6, 0);
        add_row(issue_pkg::op_sltu,  base + 2, 0, base + 5, 0, 7, 0);
        // Multiply chain keeps tag 3 pending while waiters fill the station
        test_first[4] = n_rows;
        test_name[4]  = "station full";
        base = n_rows;
        add_row(issue_pkg::op_mul,   -1, $urandom, -1, $urandom, 0, 0);
        add_row(issue_pkg::op_mul,   base, 0, -1, $urandom, 1, 0);
        add_row(issue_pkg::op_mulhu, base + 1, 0, -1, $urandom, 2, 0);
        add_row(issue_pkg::op_mul,   base + 2, 0, -1, $urandom, 3, 0);
        for (int k = 0; k < `RS_DEPTH; k++) begin
            add_row((k % 2) ? issue_pkg::op_mulhu : issue_pkg::op_mul,
                    base + 3, 0, -1, $urandom, 4 + k, 0);
        end
        add_row(issue_pkg::op_add, base + 3, 0, -1, $urandom, 12, 0);
        test_first[5] = n_rows;
    endtask

    // Rename stand-in, a produced value goes as ready data, otherwise as its tag
    task automatic resolve_src(input int rref, input logic [`XLEN-1:0] lit,
                               output logic rdy, output logic [`TAG_W-1:0] tag,
                               output logic [`XLEN-1:0] val);
        if (rref < 0) begin
            rdy = 1'b1;
            tag = '0;
            val = lit;
        end else begin
            rdy = seen[row_tag[rref]];
            tag = row_tag[rref];
            val = row_exp[rref];
        end
    endtask

    task automatic check_data(input logic [`TAG_W-1:0] tag,
                              input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error: cdb_data for tag 0x%h got 0x%h expected 0x%h", tag, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // Offer one row, held and re-resolved each cycle while full
    task automatic send_row(input int r);
        bit taken;
        int gap;
        taken = 1'b0;
        exp_data[row_tag[r]] = row_exp[r];
        pending[row_tag[r]]  = 1'b1;
        seen[row_tag[r]]     = 1'b0;
        pending_cnt++;
        dispatch_valid    = 1'b1;
        dispatch_op       = row_op[r];
        dispatch_dest_tag = row_tag[r];
        while (!taken) begin
            resolve_src(row_ref1[r], row_val1[r], dispatch_src1_ready,
                        dispatch_src1_tag, dispatch_src1_val);
            resolve_src(row_ref2[r], row_val2[r], dispatch_src2_ready,
                        dispatch_src2_tag, dispatch_src2_val);
            @(negedge clk);
            if (full) begin
                full_seen = 1'b1;
            end else begin
                taken = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        dispatch_valid = 1'b0;
        gap = (row_gap[r] < 0) ? $urandom_range(2, 0) : row_gap[r];
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs);
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s (%0d errors)", num, name, (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    task automatic run_test(input int id);
        int err0;
        err0      = errors;
        full_seen = 1'b0;
        for (int r = test_first[id]; r < test_first[id + 1]; r++) begin
            send_row(r);
        end
        wait (pending_cnt == 0);
        // A few quiet cycles so a late duplicate still shows up
        repeat (6) @(posedge clk);
        #1;
        if (id == 4) begin
            check_flag("full seen during fill", full_seen, 1'b1);
        end
        check_flag("full", full, 1'b0);
        report_test(id + 1, test_name[id], errors - err0);
    endtask

    // CDB monitor, one sample per cycle where the bus is stable
    always @(negedge clk) begin
        if (!rst && cdb_valid) begin
            if (!pending[cdb_tag]) begin
                $display("Broadcast of tag %0d that was not pending or was already seen", cdb_tag);
                errors++;
            end else begin
                check_data(cdb_tag, cdb_data, exp_data[cdb_tag]);
                pending[cdb_tag] = 1'b0;
                seen[cdb_tag]    = 1'b1;
                pending_cnt--;
            end
        end
    end

    initial begin
        int limit;
        int err0;
        void'($urandom(32'h2370_a59e));
        clk                 = 1'b0;
        rst                 = 1'b1;
        dispatch_valid      = 1'b0;
        dispatch_op         = issue_pkg::op_add;
        dispatch_src1_ready = 1'b0;
        dispatch_src1_tag   = '0;
        dispatch_src1_val   = '0;
        dispatch_src2_ready = 1'b0;
        dispatch_src2_tag   = '0;
        dispatch_src2_val   = '0;
        dispatch_dest_tag   = '0;
        n_rows       = 0;
        pending_cnt  = 0;
        errors       = 0;
        checks       = 0;
        tests_failed = 0;
        for (int t = 0; t < NTAGS; t++) begin
            pending[t]  = 1'b0;
            seen[t]     = 1'b0;
            exp_data[t] = '0;
        end
        build_table();
        limit = n_rows * (`MUL_STAGES + 20) + 50;
        fork
            begin
                repeat (limit) @(posedge clk);
                $display("Run timed out after %0d cycles with %0d results missing",
                         limit, pending_cnt);
                $display("sim failed");
                $finish;
            end
        join_none
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        // Idle state right after reset
        err0 = errors;
        @(negedge clk);
        check_flag("full", full, 1'b0);
        check_flag("cdb_valid", cdb_valid, 1'b0);
        report_test(6, "reset state", errors - err0);
        @(posedge clk);
        #1;
        for (int id = 0; id < 5; id++) begin
            run_test(id);
        end
        $display("tests 6, failed %0d, checks %0d, errors %0d", tests_failed, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
issue_pkg.sv
issue_ifs.sv
reservation_station.sv
alu_unit.sv
mult_unit.sv
cdb_arbiter.sv
issue_core.sv
tb_issue_core.sv

// ==== Bender.yml ====
package:
  name: issue_core

export_include_dirs:
  - .

sources:
  - issue_pkg.sv
  - issue_ifs.sv
  - reservation_station.sv
  - alu_unit.sv
  - mult_unit.sv
  - cdb_arbiter.sv
  - issue_core.sv
  - target: test
    files:
      - tb_issue_core.sv
